// File: source/cart_mem_pkg.sv
`default_nettype none

package cart_mem_pkg;

  // Console and PSRAM address widths
  localparam int snes_addr_w = 24;
  localparam int rom_addr_w = 24;

  // PSRAM byte address where save RAM starts
  localparam logic [rom_addr_w-1:0] saveram_base = 24'hE00000;

  typedef enum logic [0:0] {
    map_lorom,
    map_hirom
  } mapper_t;

  typedef enum logic [3:0] {
    st_idle,
    st_snes_rd_wait,
    st_snes_rd_end,
    st_snes_wr_wait1,
    st_snes_wr_data,
    st_snes_wr_wait2,
    st_snes_wr_end,
    st_mcu_rd_wait,
    st_mcu_rd_end,
    st_mcu_wr_wait,
    st_mcu_wr_end
  } arb_state_t;

endpackage

`default_nettype wire

// File: source/rom_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module rom_arbiter #(
  parameter logic [3:0] rd_wait  = 4'd4,
  parameter logic [3:0] wr_wait1 = 4'd2,
  parameter logic [3:0] wr_wait2 = 4'd3,
  parameter logic [3:0] mcu_wait = 4'd6
) (
  input  logic                               CLK2,
  input  logic                               rst_n,
  input  logic                               cycle_start,
  input  logic                               cycle_end,
  input  logic                               wr_start,
  input  logic                               is_cart,
  input  logic                               is_saveram,
  input  logic                               cpu_clk,
  input  logic [cart_mem_pkg::rom_addr_w-1:0] mapped_addr,
  input  logic [cart_mem_pkg::rom_addr_w-1:0] mcu_addr,
  input  logic [7:0]                         mcu_dout,
  input  logic                               mcu_rrq,
  input  logic                               mcu_wrq,
  input  logic [7:0]                         snes_wdata,
  output logic [cart_mem_pkg::rom_addr_w-1:0] rom_addr,
  output logic                               rom_we_n,
  output logic [7:0]                         wr_byte,
  output logic                               cap_snes,
  output logic                               cap_mcu,
  output logic                               mcu_rdy
);

  import cart_mem_pkg::*;

  arb_state_t            state;
  logic [3:0]            delay;
  logic                  delay_done;
  logic                  need_snes_addr;
  logic                  assert_snes_addr;
  logic                  console_go;
  logic                  mcu_go_rd;
  logic                  mcu_go_wr;
  logic                  mcu_rd_pend;
  logic                  mcu_wr_pend;
  logic [rom_addr_w-1:0] rom_addr_r;

  assign delay_done = (delay == 4'd0);
  assign console_go = (cycle_start | wr_start) & is_cart;

  // Console address goes straight to PSRAM while the bus is idle
  assign assert_snes_addr = cpu_clk & need_snes_addr & is_cart & (state == st_idle);
  assign rom_addr = assert_snes_addr ? mapped_addr : rom_addr_r;

  assign mcu_go_rd = (state == st_idle) & ~console_go & ~assert_snes_addr & mcu_rd_pend;
  assign mcu_go_wr = (state == st_idle) & ~console_go & ~assert_snes_addr & ~mcu_rd_pend
                     & mcu_wr_pend;

  assign cap_snes = (state == st_snes_rd_wait) | (state == st_snes_rd_end);
  assign cap_mcu  = (state == st_mcu_rd_end);

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      need_snes_addr <= 1'b0;
    end else if (cycle_end) begin
      need_snes_addr <= 1'b1;
    end else if (state == st_snes_rd_end || state == st_snes_wr_end) begin
      need_snes_addr <= 1'b0;
    end
  end

  // MCU request queue
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu_rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (state == st_mcu_rd_end || state == st_mcu_wr_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Access sequencer
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      delay      <= 4'd0;
      rom_we_n   <= 1'b1;
      rom_addr_r <= '0;
    end else if (cycle_start && is_cart) begin
      // Console always wins, even mid-access
      state      <= st_snes_rd_wait;
      delay      <= rd_wait;
      rom_we_n   <= 1'b1;
      rom_addr_r <= mapped_addr;
    end else if (wr_start && is_cart) begin
      state      <= st_snes_wr_wait1;
      delay      <= wr_wait1;
      rom_we_n   <= 1'b1;
      rom_addr_r <= mapped_addr;
    end else begin
      case (state)
        st_idle: begin
          if (mcu_go_rd) begin
            state      <= st_mcu_rd_wait;
            delay      <= mcu_wait;
            rom_addr_r <= mcu_addr;
          end else if (mcu_go_wr) begin
            state      <= st_mcu_wr_wait;
            delay      <= mcu_wait;
            rom_addr_r <= mcu_addr;
            rom_we_n   <= 1'b0;
          end
        end
        st_snes_rd_wait: begin
          delay <= delay - 4'd1;
          if (delay_done) begin
            state <= st_snes_rd_end;
          end
        end
        st_snes_wr_wait1: begin
          delay <= delay - 4'd1;
          if (delay_done) begin
            state    <= st_snes_wr_data;
            // Only save RAM takes console writes
            rom_we_n <= ~is_saveram;
          end
        end
        st_snes_wr_data: begin
          state <= st_snes_wr_wait2;
          delay <= wr_wait2;
        end
        st_snes_wr_wait2: begin
          delay <= delay - 4'd1;
          if (delay_done) begin
            state    <= st_snes_wr_end;
            rom_we_n <= 1'b1;
          end
        end
        st_mcu_rd_wait: begin
          delay <= delay - 4'd1;
          if (delay_done) begin
            state <= st_mcu_rd_end;
          end
        end
        st_mcu_wr_wait: begin
          delay <= delay - 4'd1;
          if (delay_done) begin
            state    <= st_mcu_wr_end;
            rom_we_n <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Write byte from console data or MCU
  always_ff @(posedge CLK2) begin
    if (state == st_snes_wr_data) begin
      wr_byte <= snes_wdata;
    end else if (mcu_go_wr) begin
      wr_byte <= mcu_dout;
    end
  end

  a_we_in_write: assert property (@(posedge CLK2) disable iff (!rst_n)
    !rom_we_n |-> (state inside {st_snes_wr_data, st_snes_wr_wait2, st_mcu_wr_wait}));

  a_rdy_pending: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu_rd_pend || mcu_wr_pend) |-> !mcu_rdy);

endmodule

`default_nettype wire

// File: source/rom_lane_steer.sv
`timescale 1ns/100ps
`default_nettype none

module rom_lane_steer (
  input  logic        CLK2,
  input  logic        rst_n,
  input  logic        rom_addr0,
  input  logic        rom_we_n,
  input  logic [7:0]  wr_byte,
  input  logic [15:0] rom_dq_in,
  input  logic        cap_snes,
  input  logic        cap_mcu,
  output logic [15:0] rom_dq_out,
  output logic        rom_dq_oe,
  output logic        rom_bhe_n,
  output logic        rom_ble_n,
  output logic [7:0]  snes_dout,
  output logic [7:0]  mcu_din
);

  logic [7:0] rd_byte;

  // Even address on the upper byte, odd on the lower
  assign rd_byte = rom_addr0 ? rom_dq_in[7:0] : rom_dq_in[15:8];

  // Same byte on both lanes, enables pick one
  assign rom_dq_out = {wr_byte, wr_byte};
  assign rom_dq_oe  = ~rom_we_n;

  // Both lanes enabled on reads
  assign rom_bhe_n = ~rom_we_n ? rom_addr0 : 1'b0;
  assign rom_ble_n = ~rom_we_n ? ~rom_addr0 : 1'b0;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_dout <= 8'h00;
      mcu_din   <= 8'h00;
    end else begin
      if (cap_snes) begin
        snes_dout <= rd_byte;
      end
      if (cap_mcu) begin
        mcu_din <= rd_byte;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/snes_addr_map.sv
`timescale 1ns/100ps
`default_nettype none

module snes_addr_map (
  input  logic                                CLK2,
  input  logic                                rst_n,
  input  cart_mem_pkg::mapper_t               mapper,
  input  logic [cart_mem_pkg::snes_addr_w-1:0] snes_addr,
  input  logic [cart_mem_pkg::rom_addr_w-1:0]  rom_mask,
  input  logic [cart_mem_pkg::rom_addr_w-1:0]  saveram_mask,
  output logic [cart_mem_pkg::rom_addr_w-1:0]  mapped_addr,
  output logic                                is_rom,
  output logic                                is_saveram,
  output logic                                is_cart
);

  import cart_mem_pkg::*;

  logic                  not_wram;
  logic                  lo_rom;
  logic                  lo_sram;
  logic                  hi_rom;
  logic                  hi_sram;
  logic [rom_addr_w-1:0] lo_rom_addr;
  logic [rom_addr_w-1:0] lo_sram_addr;
  logic [rom_addr_w-1:0] hi_rom_addr;
  logic [rom_addr_w-1:0] hi_sram_addr;
  logic                  sel_rom;
  logic                  sel_sram;
  logic [rom_addr_w-1:0] sel_addr;

  //////////////////////////////////////////////////////////////
  // Decode of both layouts
  //////////////////////////////////////////////////////////////

  // Banks 7E/7F belong to work RAM
  assign not_wram = (snes_addr[22:17] != 6'b111111);

  assign lo_rom  = snes_addr[15] & not_wram;
  // Banks 70..7D, lower half
  assign lo_sram = (snes_addr[22:20] == 3'b111) & (snes_addr[19:17] != 3'b111)
                   & ~snes_addr[15];
  assign hi_rom  = (snes_addr[22] | snes_addr[15]) & not_wram;
  assign hi_sram = (snes_addr[22:21] == 2'b01) & (snes_addr[15:13] == 3'b011);

  assign lo_rom_addr  = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
  assign lo_sram_addr = saveram_base
                        + ({5'b0, snes_addr[19:16], snes_addr[14:0]} & saveram_mask);
  assign hi_rom_addr  = {2'b00, snes_addr[21:0]} & rom_mask;
  assign hi_sram_addr = saveram_base
                        + ({6'b0, snes_addr[20:16], snes_addr[12:0]} & saveram_mask);

  // Save RAM wins over ROM
  always_comb begin
    case (mapper)
      map_hirom: begin
        sel_rom  = hi_rom & ~hi_sram;
        sel_sram = hi_sram;
        sel_addr = hi_sram ? hi_sram_addr : hi_rom_addr;
      end
      default: begin
        sel_rom  = lo_rom & ~lo_sram;
        sel_sram = lo_sram;
        sel_addr = lo_sram ? lo_sram_addr : lo_rom_addr;
      end
    endcase
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      mapped_addr <= '0;
      is_rom      <= 1'b0;
      is_saveram  <= 1'b0;
      is_cart     <= 1'b0;
    end else begin
      mapped_addr <= sel_addr;
      is_rom      <= sel_rom;
      is_saveram  <= sel_sram;
      is_cart     <= sel_rom | sel_sram;
    end
  end

endmodule

`default_nettype wire

// File: source/snes_bus_sync.sv
`timescale 1ns/100ps
`default_nettype none

module snes_bus_sync (
  input  logic CLK2,
  input  logic rst_n,
  input  logic cpu_clk,
  input  logic snes_wr_n,
  output logic cycle_start,
  output logic cycle_end,
  output logic wr_start
);

  logic [1:0] cpu_sync;
  logic [1:0] wr_sync;
  logic       cpu_prev;
  logic       wr_prev;

  // Two flops into CLK2, then one flop for the edge pulse
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      cpu_sync    <= 2'b00;
      wr_sync     <= 2'b11;
      cpu_prev    <= 1'b0;
      wr_prev     <= 1'b1;
      cycle_start <= 1'b0;
      cycle_end   <= 1'b0;
      wr_start    <= 1'b0;
    end else begin
      cpu_sync    <= {cpu_sync[0], cpu_clk};
      wr_sync     <= {wr_sync[0], snes_wr_n};
      cpu_prev    <= cpu_sync[1];
      wr_prev     <= wr_sync[1];
      cycle_start <= cpu_sync[1] & ~cpu_prev;
      cycle_end   <= ~cpu_sync[1] & cpu_prev;
      wr_start    <= ~wr_sync[1] & wr_prev;
    end
  end

  a_start_end_excl: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(cycle_start && cycle_end));

endmodule

`default_nettype wire

// File: source/snes_cart_top.sv
`timescale 1ns/100ps
`default_nettype none

module snes_cart_top #(
  parameter logic [3:0] rd_wait  = 4'd4,
  parameter logic [3:0] wr_wait1 = 4'd2,
  parameter logic [3:0] wr_wait2 = 4'd3,
  parameter logic [3:0] mcu_wait = 4'd6
) (
  input  logic                                CLK2,
  input  logic                                rst_n,
  input  logic [cart_mem_pkg::snes_addr_w-1:0] snes_addr,
  inout  wire  [7:0]                          snes_data,
  input  logic                                snes_rd_n,
  input  logic                                snes_wr_n,
  input  logic                                cpu_clk,
  input  cart_mem_pkg::mapper_t               mapper,
  input  logic [cart_mem_pkg::rom_addr_w-1:0]  rom_mask,
  input  logic [cart_mem_pkg::rom_addr_w-1:0]  saveram_mask,
  input  logic [cart_mem_pkg::rom_addr_w-1:0]  mcu_addr,
  input  logic [7:0]                          mcu_dout,
  input  logic                                mcu_rrq,
  input  logic                                mcu_wrq,
  output logic [7:0]                          mcu_din,
  output logic                                mcu_rdy,
  inout  wire  [15:0]                         rom_dq,
  output logic [cart_mem_pkg::rom_addr_w-2:0]  rom_addr_w,
  output logic                                rom_we_n,
  output logic                                rom_bhe_n,
  output logic                                rom_ble_n
);

  logic                                cycle_start;
  logic                                cycle_end;
  logic                                wr_start;
  logic [cart_mem_pkg::rom_addr_w-1:0] mapped_addr;
  logic                                is_saveram;
  logic                                is_cart;
  logic [cart_mem_pkg::rom_addr_w-1:0] rom_addr;
  logic [7:0]                          wr_byte;
  logic                                cap_snes;
  logic                                cap_mcu;
  logic [15:0]                         rom_dq_out;
  logic                                rom_dq_oe;
  logic [7:0]                          snes_dout;
  logic                                snes_oe;

  //////////////////////////////////////////////////////////////
  // Pads
  //////////////////////////////////////////////////////////////

  assign snes_oe    = ~snes_rd_n & is_cart;
  assign snes_data  = snes_oe ? snes_dout : 8'hzz;
  assign rom_dq     = rom_dq_oe ? rom_dq_out : 16'hzzzz;
  // PSRAM takes word addresses
  assign rom_addr_w = rom_addr[cart_mem_pkg::rom_addr_w-1:1];

  snes_bus_sync u_sync (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .cpu_clk     (cpu_clk),
    .snes_wr_n   (snes_wr_n),
    .cycle_start (cycle_start),
    .cycle_end   (cycle_end),
    .wr_start    (wr_start)
  );

  snes_addr_map u_map (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .mapper       (mapper),
    .snes_addr    (snes_addr),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .mapped_addr  (mapped_addr),
    .is_rom       (),
    .is_saveram   (is_saveram),
    .is_cart      (is_cart)
  );

  rom_arbiter #(
    .rd_wait  (rd_wait),
    .wr_wait1 (wr_wait1),
    .wr_wait2 (wr_wait2),
    .mcu_wait (mcu_wait)
  ) u_arb (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .cycle_start (cycle_start),
    .cycle_end   (cycle_end),
    .wr_start    (wr_start),
    .is_cart     (is_cart),
    .is_saveram  (is_saveram),
    .cpu_clk     (cpu_clk),
    .mapped_addr (mapped_addr),
    .mcu_addr    (mcu_addr),
    .mcu_dout    (mcu_dout),
    .mcu_rrq     (mcu_rrq),
    .mcu_wrq     (mcu_wrq),
    .snes_wdata  (snes_data),
    .rom_addr    (rom_addr),
    .rom_we_n    (rom_we_n),
    .wr_byte     (wr_byte),
    .cap_snes    (cap_snes),
    .cap_mcu     (cap_mcu),
    .mcu_rdy     (mcu_rdy)
  );

  rom_lane_steer u_lane (
    .CLK2       (CLK2),
    .rst_n      (rst_n),
    .rom_addr0  (rom_addr[0]),
    .rom_we_n   (rom_we_n),
    .wr_byte    (wr_byte),
    .rom_dq_in  (rom_dq),
    .cap_snes   (cap_snes),
    .cap_mcu    (cap_mcu),
    .rom_dq_out (rom_dq_out),
    .rom_dq_oe  (rom_dq_oe),
    .rom_bhe_n  (rom_bhe_n),
    .rom_ble_n  (rom_ble_n),
    .snes_dout  (snes_dout),
    .mcu_din    (mcu_din)
  );

endmodule

`default_nettype wire

// File: tb/psram_model.sv
`timescale 1ns/100ps
`default_nettype none

module psram_model #(
  parameter int slots = 512
) (
  input  logic        model_en,
  input  logic [22:0] word_addr,
  inout  wire  [15:0] dq,
  input  logic        we_n,
  input  logic        bhe_n,
  input  logic        ble_n
);

  // Sparse store of the 8M words, only touched words get a slot
  logic [22:0] tag [0:slots-1];
  logic [15:0] data [0:slots-1];
  int          used = 0;
  int          rev = 0;
  int          rd_slot;
  logic [15:0] rd_word;
  logic [22:0] wr_addr = '0;
  logic [15:0] wr_data = '0;
  logic        wr_hi = 1'b0;
  logic        wr_lo = 1'b0;

  // Untouched words read a pattern of the whole address
  function automatic logic [15:0] fill_word(input logic [22:0] a);
    return {a[7:0], a[15:8]} ^ {a[22:16], 9'h15a};
  endfunction

  function automatic int find_slot(input logic [22:0] a);
    int i;
    for (i = 0; i < used; i++) begin
      if (tag[i] == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic put_byte(input logic [22:0] a, input logic upper, input logic [7:0] b);
    int s;
    s = find_slot(a);
    if (s < 0) begin
      if (used >= slots) begin
        $display("psram_model: no free word slot for word address %h", a);
        return;
      end
      s = used;
      used++;
      tag[s]  = a;
      data[s] = fill_word(a);
    end
    if (upper) begin
      data[s][15:8] = b;
    end else begin
      data[s][7:0] = b;
    end
    rev++;
  endtask

  // Even byte addresses live in the upper byte
  task automatic load_byte(input logic [23:0] byte_addr, input logic [7:0] b);
    put_byte(byte_addr[23:1], ~byte_addr[0], b);
  endtask

  // Latch while WE# is low, commit on its rising edge
  always @(we_n or bhe_n or ble_n or word_addr or dq) begin
    if (!we_n) begin
      wr_addr = word_addr;
      wr_data = dq;
      wr_hi   = ~bhe_n;
      wr_lo   = ~ble_n;
    end
  end

  always @(posedge we_n) begin
    if (wr_hi) begin
      put_byte(wr_addr, 1'b1, wr_data[15:8]);
    end
    if (wr_lo) begin
      put_byte(wr_addr, 1'b0, wr_data[7:0]);
    end
  end

  always @(word_addr or rev) begin
    rd_slot = find_slot(word_addr);
    rd_word = (rd_slot < 0) ? fill_word(word_addr) : data[rd_slot];
  end

  assign dq = (model_en && we_n) ? rd_word : 16'hzzzz;

endmodule

`default_nettype wire

// File: tb/tb_snes_cart.sv
`timescale 1ns/100ps
`default_nettype none

module tb_snes_cart;

  import cart_mem_pkg::*;

  localparam int read_hold   = 24;
  localparam int rdy_timeout = 400;
  localparam int mirror_size = 512;

  logic        CLK2;
  logic        rst_n;
  logic [23:0] snes_addr;
  wire  [7:0]  snes_data;
  logic        snes_rd_n;
  logic        snes_wr_n;
  logic        cpu_clk;
  mapper_t     mapper;
  logic [23:0] rom_mask;
  logic [23:0] saveram_mask;
  logic [23:0] mcu_addr;
  logic [7:0]  mcu_dout;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic [7:0]  mcu_din;
  logic        mcu_rdy;
  wire  [15:0] rom_dq;
  logic [22:0] psram_word_addr;
  logic        rom_we_n;
  logic        rom_bhe_n;
  logic        rom_ble_n;
  logic        psram_en;
  logic [7:0]  host_data;
  logic        host_data_oe;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  logic [23:0] mirror_addr [0:mirror_size-1];
  logic [7:0]  mirror_data [0:mirror_size-1];
  int          mirror_used;

  // Console side of the data bus during writes
  assign snes_data = host_data_oe ? host_data : 8'hzz;

  snes_cart_top uut (
    .CLK2         (CLK2),
    .rst_n        (rst_n),
    .snes_addr    (snes_addr),
    .snes_data    (snes_data),
    .snes_rd_n    (snes_rd_n),
    .snes_wr_n    (snes_wr_n),
    .cpu_clk      (cpu_clk),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .mcu_addr     (mcu_addr),
    .mcu_dout     (mcu_dout),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_din      (mcu_din),
    .mcu_rdy      (mcu_rdy),
    .rom_dq       (rom_dq),
    .rom_addr_w   (psram_word_addr),
    .rom_we_n     (rom_we_n),
    .rom_bhe_n    (rom_bhe_n),
    .rom_ble_n    (rom_ble_n)
  );

  psram_model u_psram (
    .model_en  (psram_en),
    .word_addr (psram_word_addr),
    .dq        (rom_dq),
    .we_n      (rom_we_n),
    .bhe_n     (rom_bhe_n),
    .ble_n     (rom_ble_n)
  );

  always #20 CLK2 = ~CLK2;

  ////////////////////////////////////////////////////////////
  // Random bits, mirror and address helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic int mirror_find(input logic [23:0] a);
    int i;
    for (i = 0; i < mirror_used; i++) begin
      if (mirror_addr[i] == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic [7:0] mirror_read(input logic [23:0] a);
    int s;
    s = mirror_find(a);
    return (s < 0) ? 8'hxx : mirror_data[s];
  endfunction

  task automatic mirror_write(input logic [23:0] a, input logic [7:0] d);
    int s;
    s = mirror_find(a);
    if (s < 0) begin
      if (mirror_used >= mirror_size) begin
        errors++;
        $display("Mirror table is full, byte address %h not tracked", a);
        return;
      end
      s = mirror_used;
      mirror_used++;
      mirror_addr[s] = a;
    end
    mirror_data[s] = d;
  endtask

  // Random byte into PSRAM and mirror unless already known
  task automatic preload(input logic [23:0] a);
    logic [7:0] d;
    if (mirror_find(a) < 0) begin
      d = rand_bits(8);
      mirror_write(a, d);
      u_psram.load_byte(a, d);
    end
  endtask

  function automatic logic [23:0] lorom_rom_map(input logic [23:0] a);
    return {2'b00, a[22:16], a[14:0]} & rom_mask;
  endfunction

  function automatic logic [23:0] hirom_rom_map(input logic [23:0] a);
    return {2'b00, a[21:0]} & rom_mask;
  endfunction

  function automatic logic [23:0] lorom_sram_map(input logic [23:0] a);
    return saveram_base + ({5'b0, a[19:16], a[14:0]} & saveram_mask);
  endfunction

  function automatic logic [23:0] rand_lorom_rom();
    logic [6:0]  bank;
    logic [14:0] ofs;
    bank = rand_bits(7);
    ofs  = rand_bits(15);
    // Keep clear of work RAM banks
    if (bank[6:1] == 6'h3f) begin
      bank[6] = 1'b0;
    end
    return {1'b0, bank, 1'b1, ofs};
  endfunction

  function automatic logic [23:0] rand_hirom_rom();
    logic [5:0]  low_bank;
    logic [15:0] ofs;
    low_bank = rand_bits(6);
    ofs      = rand_bits(16);
    if (low_bank[5:1] == 5'h1f) begin
      low_bank[5] = 1'b0;
    end
    return {2'b01, low_bank, ofs};
  endfunction

  function automatic logic [23:0] rand_lorom_sram();
    logic [6:0]  bank;
    logic [14:0] ofs;
    int          n;
    n    = rand_bits(4);
    ofs  = rand_bits(15);
    bank = 7'h70 + n % 14;
    return {1'b0, bank, 1'b0, ofs};
  endfunction

  task automatic check(input string test, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %0h, actual %0h", test, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  task automatic console_read(input logic [23:0] addr, output logic [7:0] data);
    @(negedge CLK2);
    snes_addr = addr;
    snes_rd_n = 1'b0;
    repeat (2) @(negedge CLK2);
    cpu_clk = 1'b1;
    repeat (read_hold) @(negedge CLK2);
    data      = snes_data;
    cpu_clk   = 1'b0;
    snes_rd_n = 1'b1;
    repeat (6) @(negedge CLK2);
  endtask

  task automatic console_write(input logic [23:0] addr, input logic [7:0] data);
    @(negedge CLK2);
    snes_addr    = addr;
    host_data    = data;
    host_data_oe = 1'b1;
    repeat (2) @(negedge CLK2);
    snes_wr_n = 1'b0;
    repeat (20) @(negedge CLK2);
    snes_wr_n    = 1'b1;
    host_data_oe = 1'b0;
    repeat (6) @(negedge CLK2);
  endtask

  task automatic wait_rdy(input string test);
    int n;
    n = 0;
    while (mcu_rdy !== 1'b1 && n < rdy_timeout) begin
      @(negedge CLK2);
      n++;
    end
    if (mcu_rdy !== 1'b1) begin
      errors++;
      $display("Timeout in %s: mcu_rdy stayed low for %0d cycles", test, rdy_timeout);
    end
  endtask

  task automatic mcu_write(input logic [23:0] addr, input logic [7:0] data);
    @(negedge CLK2);
    mcu_addr = addr;
    mcu_dout = data;
    mcu_wrq  = 1'b1;
    @(negedge CLK2);
    mcu_wrq = 1'b0;
    wait_rdy("mcu_write");
  endtask

  task automatic mcu_read(input logic [23:0] addr, output logic [7:0] data);
    @(negedge CLK2);
    mcu_addr = addr;
    mcu_rrq  = 1'b1;
    @(negedge CLK2);
    mcu_rrq = 1'b0;
    wait_rdy("mcu_read");
    data = mcu_din;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge CLK2);
    check("reset_mcu_rdy", 1'b1, mcu_rdy);
    check("reset_rom_we_n", 1'b1, rom_we_n);
    check("reset_snes_data", 8'hzz, snes_data);
    // PSRAM model is still off, so only the DUT could drive
    check("reset_rom_dq", 16'hzzzz, rom_dq);
    psram_en = 1'b1;
  endtask

  task automatic test_rom_reads(input mapper_t layout, input string test);
    logic [23:0] addr;
    logic [23:0] m;
    logic [7:0]  got;
    int          k;
    @(negedge CLK2);
    mapper = layout;
    for (k = 0; k < 8; k++) begin
      if (layout == map_hirom) begin
        addr = rand_hirom_rom();
        m    = hirom_rom_map(addr);
      end else begin
        addr = rand_lorom_rom();
        m    = lorom_rom_map(addr);
      end
      preload(m);
      console_read(addr, got);
      check(test, mirror_read(m), got);
    end
  endtask

  task automatic test_console_writes();
    logic [23:0] addr;
    logic [23:0] m;
    logic [7:0]  d;
    logic [7:0]  got;
    int          k;
    @(negedge CLK2);
    mapper = map_lorom;
    for (k = 0; k < 4; k++) begin
      addr = rand_lorom_sram();
      m    = lorom_sram_map(addr);
      d    = rand_bits(8);
      console_write(addr, d);
      mirror_write(m, d);
      console_read(addr, got);
      check("sram_write_readback", d, got);
    end
    // ROM ignores console writes
    for (k = 0; k < 2; k++) begin
      addr = rand_lorom_rom();
      m    = lorom_rom_map(addr);
      preload(m);
      console_write(addr, ~mirror_read(m));
      console_read(addr, got);
      check("rom_write_ignored", mirror_read(m), got);
    end
  endtask

  task automatic test_mcu_access();
    logic [22:0] w;
    logic [23:0] a0;
    logic [7:0]  d0;
    logic [7:0]  d1;
    logic [7:0]  got;
    w  = rand_bits(23);
    a0 = {w, 1'b0};
    d0 = rand_bits(8);
    d1 = rand_bits(8);
    mcu_write(a0, d0);
    mirror_write(a0, d0);
    mcu_write(a0 | 24'd1, d1);
    mirror_write(a0 | 24'd1, d1);
    mcu_read(a0, got);
    check("mcu_even_lane", d0, got);
    mcu_read(a0 | 24'd1, got);
    check("mcu_odd_lane", d1, got);
  endtask

  task test_contention();
    logic [23:0] mcu_target;
    logic [23:0] addr;
    logic [23:0] m;
    logic [7:0]  got;
    int          k;
    mcu_target = rand_bits(24);
    preload(mcu_target);
    @(negedge CLK2);
    mapper   = map_lorom;
    mcu_addr = mcu_target;
    mcu_rrq  = 1'b1;
    @(negedge CLK2);
    mcu_rrq = 1'b0;
    fork
      begin
        for (k = 0; k < 3; k++) begin
          addr = rand_lorom_rom();
          m    = lorom_rom_map(addr);
          preload(m);
          console_read(addr, got);
          check("contention_console", mirror_read(m), got);
        end
      end
      begin
        wait_rdy("contention_mcu");
        check("contention_mcu", mirror_read(mcu_target), mcu_din);
      end
    join
  endtask

  initial begin
    CLK2         = 1'b0;
    rst_n        = 1'b0;
    snes_addr    = '0;
    snes_rd_n    = 1'b1;
    snes_wr_n    = 1'b1;
    cpu_clk      = 1'b0;
    mapper       = map_lorom;
    rom_mask     = 24'h3fffff;
    saveram_mask = 24'h001fff;
    mcu_addr     = '0;
    mcu_dout     = 8'h00;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    psram_en     = 1'b0;
    host_data    = 8'h00;
    host_data_oe = 1'b0;
    lfsr         = 32'h5680147b;
    errors       = 0;
    checks       = 0;
    mirror_used  = 0;
    repeat (8) @(negedge CLK2);
    rst_n = 1'b1;

    test_reset();
    test_rom_reads(map_lorom, "lorom_read");
    test_rom_reads(map_hirom, "hirom_read");
    test_console_writes();
    test_mcu_access();
    test_contention();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
source/cart_mem_pkg.sv
source/snes_bus_sync.sv
source/snes_addr_map.sv
source/rom_arbiter.sv
source/rom_lane_steer.sv
source/snes_cart_top.sv
tb/psram_model.sv
tb/tb_snes_cart.sv
